// File: design/dpsram.sv
`timescale 1ns/1ps

module dpsram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DEPTH      = 64
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    // port 0, read only
    input  logic                            en0_i,
    input  logic [$clog2(DEPTH)-1:0]        addr0_i,
    output logic [DATA_WIDTH-1:0]           rdata0_o,
    // port 1, read and byte write
    input  logic                            en1_i,
    input  logic [(DATA_WIDTH+7)/8-1:0]     we1_i,
    input  logic [$clog2(DEPTH)-1:0]        addr1_i,
    input  logic [DATA_WIDTH-1:0]           wdata1_i,
    output logic [DATA_WIDTH-1:0]           rdata1_o
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [DATA_WIDTH-1:0] wr_merged;

    // old word with the enabled bytes replaced
    always_comb begin
        wr_merged = mem[addr1_i];
        for (int b = 0; b < DATA_WIDTH; b++) begin
            if (we1_i[b/8]) begin
                wr_merged[b] = wdata1_i[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en1_i && (|we1_i)) begin
            mem[addr1_i] <= wr_merged;
        end
    end

    // port 1 is write-first, it returns the merged word
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rdata0_o <= '0;
            rdata1_o <= '0;
        end else begin
            if (en0_i) begin
                rdata0_o <= mem[addr0_i];
            end
            if (en1_i) begin
                rdata1_o <= wr_merged;
            end
        end
    end

    // the owner must steer a same-address read to port 1
    a_no_read_on_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(en0_i && en1_i && (|we1_i) && (addr0_i == addr1_i)))
        else $error("dpsram port 0 read collides with port 1 write");

endmodule

// File: design/icache.sv
`timescale 1ns/1ps

module icache import icache_pkg::*; #(
    parameter int unsigned WAY_NUM      = 2,
    parameter int unsigned SET_NUM      = 64,
    parameter int unsigned BLOCK_WORDS  = 8,
    parameter logic [3:0]  UNCACHED_SEG = 4'hA
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           fetch_valid_i,
    input  logic [ADDR_W-1:0]              fetch_addr_i,
    output logic                           stall_o,
    output logic                           resp_valid_o,
    output logic [INST_W-1:0]              resp_inst_o,
    input  logic                           busy_i,
    input  logic                           replay_i,
    input  logic                           done_i,
    input  logic [INST_W-1:0]              done_inst_i,
    output logic                           miss_req_o,
    output logic [ADDR_W-1:0]              miss_addr_o,
    output logic                           miss_uncached_o,
    input  logic [$clog2(SET_NUM)-1:0]     wr_index_i,
    input  logic [$clog2(BLOCK_WORDS)-1:0] wr_word_i,
    input  logic [WAY_NUM-1:0]             wr_tag_we_i,
    input  logic [WAY_NUM-1:0]             wr_data_we_i,
    input  logic [TAG_ENTRY_W-1:0]         wr_tag_i,
    input  logic [INST_W-1:0]              wr_data_i
);

    localparam int unsigned INDEX_W   = $clog2(SET_NUM);
    localparam int unsigned WORD_W    = $clog2(BLOCK_WORDS);
    localparam int unsigned INDEX_LSB = BYTE_OFF_W + WORD_W;

    logic s0_valid, s1_valid;
    logic [ADDR_W-1:0] s0_addr, s1_addr, rd_addr;
    logic adv, rd_en;
    logic s1_unc, s1_hit, s1_miss;
    logic [WAY_NUM-1:0] hit_way;
    logic [TAG_ENTRY_W-1:0] way_tag [WAY_NUM];
    logic [INST_W-1:0] way_data [WAY_NUM];
    logic [INST_W-1:0] hit_data;

    assign adv = !stall_o;

    // replay rereads the held stage 1 address, stage 0 waits behind it
    assign rd_addr = replay_i ? s1_addr : s0_addr;
    assign rd_en   = replay_i || (adv && s0_valid);

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        icache_way_array #(
            .SET_NUM     (SET_NUM),
            .BLOCK_WORDS (BLOCK_WORDS)
        ) u_way (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .rd_en_i    (rd_en),
            .rd_index_i (rd_addr[INDEX_LSB +: INDEX_W]),
            .rd_word_i  (rd_addr[BYTE_OFF_W +: WORD_W]),
            .wr_index_i (wr_index_i),
            .wr_word_i  (wr_word_i),
            .tag_we_i   (wr_tag_we_i[w]),
            .data_we_i  (wr_data_we_i[w]),
            .wr_tag_i   (wr_tag_i),
            .wr_data_i  (wr_data_i),
            .tag_o      (way_tag[w]),
            .data_o     (way_data[w])
        );

        assign hit_way[w] = way_tag[w][TAG_ENTRY_W-1] &&
                            (way_tag[w][TAG_W-1:0] == s1_addr[ADDR_W-1:PAGE_OFF_W]);
    end

    // one-hot select of the hit way
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_data = hit_data | (way_data[w] & {INST_W{hit_way[w]}});
        end
    end

    assign s1_unc  = (s1_addr[ADDR_W-1 -: 4] == UNCACHED_SEG);
    assign s1_hit  = s1_valid && !s1_unc && (|hit_way);
    assign s1_miss = s1_valid && !s1_hit;

    assign stall_o = busy_i || s1_miss;

    assign miss_req_o      = s1_miss;
    assign miss_addr_o     = s1_addr;
    assign miss_uncached_o = s1_unc;

    // uncached word arrives while stage 1 is empty
    assign resp_valid_o = s1_hit || done_i;
    assign resp_inst_o  = done_i ? done_inst_i : hit_data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            if (adv) begin
                s0_valid <= fetch_valid_i;
            end
            if (replay_i) begin
                s1_valid <= 1'b1;
            end else if (adv) begin
                s1_valid <= s0_valid;
            end else if (s1_miss) begin
                // handed to the refill engine
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            s0_addr <= fetch_addr_i;
            s1_addr <= s0_addr;
        end
    end

    a_one_hit_way: assert property (@(posedge clk) disable iff (!rst_n_i)
        s1_valid |-> $onehot0(hit_way))
        else $error("more than one way hits for %h", s1_addr);

endmodule

// File: design/icache_pkg.sv
package icache_pkg;

    // fetch and memory word widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned INST_W = 32;

    // byte offset inside a 32-bit word
    localparam int unsigned BYTE_OFF_W = 2;

    // index and block offset live inside the page offset
    localparam int unsigned PAGE_OFF_W = 12;

    // tag is address bits 31:12
    localparam int unsigned TAG_W = ADDR_W - PAGE_OFF_W;

    // tag ram word, valid bit on top of the tag
    localparam int unsigned TAG_ENTRY_W = TAG_W + 1;

    // burst length field on the memory request
    localparam int unsigned MEM_LEN_W = 4;

endpackage

// File: design/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; #(
    parameter int unsigned WAY_NUM     = 2,
    parameter int unsigned SET_NUM     = 64,
    parameter int unsigned BLOCK_WORDS = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           miss_req_i,
    input  logic [ADDR_W-1:0]              miss_addr_i,
    input  logic                           miss_uncached_i,
    input  logic                           inv_valid_i,
    input  logic [ADDR_W-1:0]              inv_addr_i,
    output logic                           mem_req_o,
    output logic [ADDR_W-1:0]              mem_addr_o,
    output logic [MEM_LEN_W-1:0]           mem_len_o,
    input  logic                           mem_rvalid_i,
    input  logic [INST_W-1:0]              mem_rdata_i,
    output logic                           busy_o,
    output logic                           replay_o,
    output logic                           done_o,
    output logic [INST_W-1:0]              done_inst_o,
    output logic [$clog2(SET_NUM)-1:0]     wr_index_o,
    output logic [$clog2(BLOCK_WORDS)-1:0] wr_word_o,
    output logic [WAY_NUM-1:0]             wr_tag_we_o,
    output logic [WAY_NUM-1:0]             wr_data_we_o,
    output logic [TAG_ENTRY_W-1:0]         wr_tag_o,
    output logic [INST_W-1:0]              wr_data_o
);

    localparam int unsigned INDEX_W   = $clog2(SET_NUM);
    localparam int unsigned WORD_W    = $clog2(BLOCK_WORDS);
    localparam int unsigned INDEX_LSB = BYTE_OFF_W + WORD_W;
    localparam int unsigned VICTIM_W  = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

    localparam logic [2:0] S_INIT     = 3'd0;
    localparam logic [2:0] S_NORMAL   = 3'd1;
    localparam logic [2:0] S_REFILL   = 3'd2;
    localparam logic [2:0] S_UNCACHED = 3'd3;
    localparam logic [2:0] S_FINISH   = 3'd4;

    logic [2:0] state;
    logic [INDEX_W-1:0] init_cnt;
    logic [INDEX_W-1:0] line_index;
    logic [TAG_W-1:0] line_tag;
    logic [WORD_W-1:0] word_cnt;
    logic [VICTIM_W-1:0] victim, way_sel;
    logic [WAY_NUM-1:0] way_mask;
    logic inv_pend, inv_write;
    logic [INDEX_W-1:0] inv_index;

    assign busy_o    = (state != S_NORMAL);
    assign replay_o  = (state == S_FINISH);
    assign way_mask  = WAY_NUM'(1) << way_sel;
    // invalidate uses port 1 only while idle
    assign inv_write = (state == S_NORMAL) && inv_pend;

    always_comb begin
        wr_index_o   = line_index;
        wr_word_o    = word_cnt;
        wr_tag_we_o  = '0;
        wr_data_we_o = '0;
        wr_tag_o     = {1'b1, line_tag};
        wr_data_o    = mem_rdata_i;
        if (state == S_INIT) begin
            wr_index_o  = init_cnt;
            wr_tag_we_o = '1;
            wr_tag_o    = '0;
        end else if (inv_write) begin
            wr_index_o  = inv_index;
            wr_tag_we_o = '1;
            wr_tag_o    = '0;
        end else if (state == S_REFILL && mem_rvalid_i) begin
            wr_data_we_o = way_mask;
            // first word of the block also sets the tag
            if (word_cnt == '0) begin
                wr_tag_we_o = way_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state     <= S_INIT;
            init_cnt  <= '0;
            word_cnt  <= '0;
            victim    <= '0;
            way_sel   <= '0;
            inv_pend  <= 1'b0;
            mem_req_o <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            mem_req_o <= 1'b0;
            done_o    <= 1'b0;
            if (inv_valid_i) begin
                inv_pend <= 1'b1;
            end else if (inv_write) begin
                inv_pend <= 1'b0;
            end
            case (state)
                S_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == INDEX_W'(SET_NUM - 1)) begin
                        state <= S_NORMAL;
                    end
                end
                S_NORMAL: begin
                    if (miss_req_i) begin
                        mem_req_o <= 1'b1;
                        word_cnt  <= '0;
                        if (miss_uncached_i) begin
                            state <= S_UNCACHED;
                        end else begin
                            state   <= S_REFILL;
                            way_sel <= victim;
                            // round robin, one step per refill
                            if (WAY_NUM > 1) begin
                                victim <= victim + 1'b1;
                            end
                        end
                    end
                end
                S_REFILL: begin
                    if (mem_rvalid_i) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == WORD_W'(BLOCK_WORDS - 1)) begin
                            state <= S_FINISH;
                        end
                    end
                end
                S_UNCACHED: begin
                    if (mem_rvalid_i) begin
                        done_o <= 1'b1;
                        state  <= S_NORMAL;
                    end
                end
                default: state <= S_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // a later invalidate replaces a pending one
        if (inv_valid_i) begin
            inv_index <= inv_addr_i[INDEX_LSB +: INDEX_W];
        end
        if (state == S_NORMAL && miss_req_i) begin
            line_index <= miss_addr_i[INDEX_LSB +: INDEX_W];
            line_tag   <= miss_addr_i[ADDR_W-1:PAGE_OFF_W];
            if (miss_uncached_i) begin
                mem_addr_o <= {miss_addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
                mem_len_o  <= MEM_LEN_W'(1);
            end else begin
                mem_addr_o <= {miss_addr_i[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
                mem_len_o  <= MEM_LEN_W'(BLOCK_WORDS);
            end
        end
        if (state == S_UNCACHED && mem_rvalid_i) begin
            done_inst_o <= mem_rdata_i;
        end
    end

    a_rvalid_in_fill: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rvalid_i |-> (state == S_REFILL || state == S_UNCACHED))
        else $error("mem_rvalid_i while no memory read is open");

endmodule

// File: design/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int unsigned WAY_NUM      = 2,
    parameter int unsigned SET_NUM      = 64,
    parameter int unsigned BLOCK_WORDS  = 8,
    parameter logic [3:0]  UNCACHED_SEG = 4'hA
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fetch_valid_i,
    input  logic [ADDR_W-1:0]    fetch_addr_i,
    output logic                 stall_o,
    output logic                 resp_valid_o,
    output logic [INST_W-1:0]    resp_inst_o,
    input  logic                 inv_valid_i,
    input  logic [ADDR_W-1:0]    inv_addr_i,
    output logic                 mem_req_o,
    output logic [ADDR_W-1:0]    mem_addr_o,
    output logic [MEM_LEN_W-1:0] mem_len_o,
    input  logic                 mem_rvalid_i,
    input  logic [INST_W-1:0]    mem_rdata_i
);

    logic busy, replay, done;
    logic [INST_W-1:0] done_inst;
    logic miss_req, miss_uncached;
    logic [ADDR_W-1:0] miss_addr;
    logic [$clog2(SET_NUM)-1:0] wr_index;
    logic [$clog2(BLOCK_WORDS)-1:0] wr_word;
    logic [WAY_NUM-1:0] wr_tag_we, wr_data_we;
    logic [TAG_ENTRY_W-1:0] wr_tag;
    logic [INST_W-1:0] wr_data;

    icache #(
        .WAY_NUM      (WAY_NUM),
        .SET_NUM      (SET_NUM),
        .BLOCK_WORDS  (BLOCK_WORDS),
        .UNCACHED_SEG (UNCACHED_SEG)
    ) u_icache (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_addr_i    (fetch_addr_i),
        .stall_o         (stall_o),
        .resp_valid_o    (resp_valid_o),
        .resp_inst_o     (resp_inst_o),
        .busy_i          (busy),
        .replay_i        (replay),
        .done_i          (done),
        .done_inst_i     (done_inst),
        .miss_req_o      (miss_req),
        .miss_addr_o     (miss_addr),
        .miss_uncached_o (miss_uncached),
        .wr_index_i      (wr_index),
        .wr_word_i       (wr_word),
        .wr_tag_we_i     (wr_tag_we),
        .wr_data_we_i    (wr_data_we),
        .wr_tag_i        (wr_tag),
        .wr_data_i       (wr_data)
    );

    icache_refill #(
        .WAY_NUM     (WAY_NUM),
        .SET_NUM     (SET_NUM),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_refill (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .miss_req_i      (miss_req),
        .miss_addr_i     (miss_addr),
        .miss_uncached_i (miss_uncached),
        .inv_valid_i     (inv_valid_i),
        .inv_addr_i      (inv_addr_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_len_o       (mem_len_o),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .busy_o          (busy),
        .replay_o        (replay),
        .done_o          (done),
        .done_inst_o     (done_inst),
        .wr_index_o      (wr_index),
        .wr_word_o       (wr_word),
        .wr_tag_we_o     (wr_tag_we),
        .wr_data_we_o    (wr_data_we),
        .wr_tag_o        (wr_tag),
        .wr_data_o       (wr_data)
    );

endmodule

// File: design/icache_way_array.sv
`timescale 1ns/1ps

module icache_way_array import icache_pkg::*; #(
    parameter int unsigned SET_NUM     = 64,
    parameter int unsigned BLOCK_WORDS = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           rd_en_i,
    input  logic [$clog2(SET_NUM)-1:0]     rd_index_i,
    input  logic [$clog2(BLOCK_WORDS)-1:0] rd_word_i,
    input  logic [$clog2(SET_NUM)-1:0]     wr_index_i,
    input  logic [$clog2(BLOCK_WORDS)-1:0] wr_word_i,
    input  logic                           tag_we_i,
    input  logic                           data_we_i,
    input  logic [TAG_ENTRY_W-1:0]         wr_tag_i,
    input  logic [INST_W-1:0]              wr_data_i,
    output logic [TAG_ENTRY_W-1:0]         tag_o,
    output logic [INST_W-1:0]              data_o
);

    localparam int unsigned TAG_BYTES  = (TAG_ENTRY_W + 7) / 8;
    localparam int unsigned DATA_BYTES = INST_W / 8;

    logic tag_match, tag_match_q;
    logic data_match, data_match_q;
    logic [TAG_ENTRY_W-1:0] tag_p0, tag_p1;
    logic [INST_W-1:0] data_p0, data_p1;

    // tag entry is per set, data entry per word
    assign tag_match  = (rd_index_i == wr_index_i);
    assign data_match = ({rd_index_i, rd_word_i} == {wr_index_i, wr_word_i});

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tag_match_q  <= 1'b0;
            data_match_q <= 1'b0;
        end else begin
            tag_match_q  <= rd_en_i && tag_match;
            data_match_q <= rd_en_i && data_match;
        end
    end

    assign tag_o  = tag_match_q ? tag_p1 : tag_p0;
    assign data_o = data_match_q ? data_p1 : data_p0;

    dpsram #(.DATA_WIDTH(TAG_ENTRY_W), .DEPTH(SET_NUM)) u_tag_ram (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en0_i    (rd_en_i && !tag_match),
        .addr0_i  (rd_index_i),
        .rdata0_o (tag_p0),
        .en1_i    (1'b1),
        .we1_i    ({TAG_BYTES{tag_we_i}}),
        .addr1_i  (wr_index_i),
        .wdata1_i (wr_tag_i),
        .rdata1_o (tag_p1)
    );

    dpsram #(.DATA_WIDTH(INST_W), .DEPTH(SET_NUM * BLOCK_WORDS)) u_data_ram (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en0_i    (rd_en_i && !data_match),
        .addr0_i  ({rd_index_i, rd_word_i}),
        .rdata0_o (data_p0),
        .en1_i    (1'b1),
        .we1_i    ({DATA_BYTES{data_we_i}}),
        .addr1_i  ({wr_index_i, wr_word_i}),
        .wdata1_i (wr_data_i),
        .rdata1_o (data_p1)
    );

    // a valid tag is only written together with word 0 of its block
    a_tag_with_word0: assert property (@(posedge clk) disable iff (!rst_n_i)
        (tag_we_i && wr_tag_i[TAG_ENTRY_W-1]) |-> (data_we_i && (wr_word_i == '0)))
        else $error("valid tag written without word 0 of the block");

endmodule

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
LOG=sim.log
rm -f "$LOG"
verilator --binary --assert -j 0 --top-module icache_tb -f src.f \
    && ./obj_dir/Vicache_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }
cat "$LOG"
grep -q "=== FAIL ===" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" "$LOG" || { echo "no result line in $LOG"; exit 1; }
echo "simulation passed"

// File: src.f
design/icache_pkg.sv
design/dpsram.sv
design/icache_way_array.sv
design/icache_refill.sv
design/icache.sv
design/icache_top.sv
tb/tb_clock.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// File: tb/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter logic [31:0] SEED     = 32'h1,
    parameter logic [31:0] WORD_XOR = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    input  logic [3:0]  mem_len_i,
    output logic        mem_rvalid_o,
    output logic [31:0] mem_rdata_o
);

    logic [31:0] addr;
    int unsigned left;
    int unsigned delay;

    // single process, so every random draw comes from one seeded stream
    initial begin
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (rst_n_i && mem_req_i) begin
                addr  = mem_addr_i;
                left  = 32'(mem_len_i);
                // first word 1 to 4 cycles after the request
                delay = 1 + ($urandom % 4);
                repeat (delay) @(negedge clk);
                while (left > 0) begin
                    mem_rvalid_o = 1'b1;
                    mem_rdata_o  = addr ^ WORD_XOR;
                    @(negedge clk);
                    mem_rvalid_o = 1'b0;
                    addr = addr + 32'd4;
                    left = left - 1;
                    // idle gap of 0 to 2 cycles between words
                    if (left > 0) begin
                        repeat ($urandom % 3) @(negedge clk);
                    end
                end
            end
        end
    end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int WAY_NUM = 2;
    localparam int SET_NUM = 64;
    localparam int BLOCK_WORDS = 8;
    localparam logic [3:0] UNCACHED_SEG = 4'hA;
    localparam logic [31:0] WORD_XOR = 32'h5a5a_c3c3;
    localparam logic [31:0] SEED = 32'h75f5_2bd1;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_ENTRIES = 18;

    typedef struct packed {
        logic        inv;
        logic [31:0] addr;
        logic [3:0]  reqs;
    } stim_t;

    // invalidate flag, address, memory requests expected for the entry
    stim_t stim_table [NUM_ENTRIES] = '{
        '{1'b0, 32'h0000_1040, 4'd1},
        '{1'b0, 32'h0000_1040, 4'd0},
        '{1'b0, 32'h0000_105c, 4'd0},
        '{1'b0, 32'h0000_2040, 4'd1},
        // third tag in set 2 evicts way 0
        '{1'b0, 32'h0000_3048, 4'd1},
        '{1'b0, 32'h0000_2044, 4'd0},
        '{1'b0, 32'h0000_1040, 4'd1},
        '{1'b0, 32'h0000_3048, 4'd0},
        '{1'b0, 32'h0000_2040, 4'd1},
        '{1'b0, 32'h0000_1044, 4'd0},
        '{1'b0, 32'ha000_0100, 4'd1},
        '{1'b0, 32'ha000_0100, 4'd1},
        '{1'b0, 32'ha000_0104, 4'd1},
        '{1'b0, 32'h0000_5180, 4'd1},
        '{1'b0, 32'h0000_5184, 4'd0},
        '{1'b1, 32'h0000_5180, 4'd0},
        '{1'b0, 32'h0000_5188, 4'd1},
        '{1'b0, 32'h0000_5180, 4'd0}
    };

    logic clk, rst_n;
    logic fetch_valid, stall, resp_valid, inv_valid;
    logic [31:0] fetch_addr, resp_inst, inv_addr;
    logic mem_req, mem_rvalid;
    logic [31:0] mem_addr, mem_rdata;
    logic [3:0] mem_len;
    logic [31:0] exp_mem_addr;
    logic [3:0] exp_mem_len;

    int err_count = 0;
    int timeout_count = 0;
    int resp_count = 0;
    int req_count = 0;
    int req_errors = 0;

    tb_clock #(.HALF_PERIOD(5), .RESET_CYCLES(8)) u_clock (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    icache_top #(
        .WAY_NUM      (WAY_NUM),
        .SET_NUM      (SET_NUM),
        .BLOCK_WORDS  (BLOCK_WORDS),
        .UNCACHED_SEG (UNCACHED_SEG)
    ) dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .fetch_valid_i (fetch_valid),
        .fetch_addr_i  (fetch_addr),
        .stall_o       (stall),
        .resp_valid_o  (resp_valid),
        .resp_inst_o   (resp_inst),
        .inv_valid_i   (inv_valid),
        .inv_addr_i    (inv_addr),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr),
        .mem_len_o     (mem_len),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rdata_i   (mem_rdata)
    );

    icache_mem_model #(.SEED(SEED), .WORD_XOR(WORD_XOR)) u_mem (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .mem_req_i    (mem_req),
        .mem_addr_i   (mem_addr),
        .mem_len_i    (mem_len),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata)
    );

    // every request pulse is counted and matched to the fetch that missed
    always @(negedge clk) begin : count_mem_requests
        if (rst_n && mem_req) begin
            req_count++;
            assert (mem_addr == exp_mem_addr) else begin
                req_errors++;
                $display("FAILED mem_addr_o exp=%h got=%h", exp_mem_addr, mem_addr);
            end
            assert (mem_len == exp_mem_len) else begin
                req_errors++;
                $display("FAILED mem_len_o exp=%h got=%h", exp_mem_len, mem_len);
            end
        end
    end

    // block start and length for a cached miss, one word for uncached
    task automatic expect_mem_request(input logic [31:0] addr);
        if (addr[31:28] == UNCACHED_SEG) begin
            exp_mem_addr = {addr[31:2], 2'b00};
            exp_mem_len  = 4'd1;
        end else begin
            exp_mem_addr = addr & ~(32'(BLOCK_WORDS * 4) - 32'd1);
            exp_mem_len  = 4'(BLOCK_WORDS);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        err_count++;
        $display("FAILED %s exp=%h got=%h", name, exp_val, got_val);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic send_invalidate(input logic [31:0] addr);
        @(negedge clk);
        inv_valid = 1'b1;
        inv_addr  = addr;
        @(negedge clk);
        inv_valid = 1'b0;
    endtask

    // n fetches of consecutive words with fetch_valid held high
    task automatic run_fetches(input logic [31:0] base, input int n, input bit check_lat);
        logic [31:0] addr_q [$];
        int acc_q [$];
        logic [31:0] a, exp_inst;
        int acc, sent, got, cyc;
        bit taken;
        sent = 0;
        got = 0;
        cyc = 0;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr  = base;
        while (got < n && cyc < TIMEOUT_CYCLES) begin
            if (resp_valid) begin
                got++;
                resp_count++;
                if (addr_q.size() == 0) begin
                    err_count++;
                    $display("response arrived with no fetch in flight");
                end else begin
                    a = addr_q.pop_front();
                    acc = acc_q.pop_front();
                    exp_inst = {a[31:2], 2'b00} ^ WORD_XOR;
                    assert (resp_inst == exp_inst)
                        else report_mismatch("resp_inst_o", exp_inst, resp_inst);
                    if (check_lat) begin
                        assert (cyc - acc == 2)
                            else report_mismatch("resp_valid_o latency", 32'd2, 32'(cyc - acc));
                    end
                end
            end
            // stall is stable here, so the next rising edge takes the request
            taken = fetch_valid && !stall;
            if (taken) begin
                addr_q.push_back(fetch_addr);
                acc_q.push_back(cyc);
                sent++;
            end
            @(negedge clk);
            cyc++;
            // next fetch goes out once the edge has taken this one
            if (taken) begin
                if (sent < n) begin
                    fetch_addr = base + 32'(4 * sent);
                end else begin
                    fetch_valid = 1'b0;
                end
            end
        end
        fetch_valid = 1'b0;
        if (got < n) begin
            report_timeout($sformatf("responses to fetches from %h", base));
        end
    endtask

    initial begin
        int wait_cnt;
        int busy_cycles;
        int req_start;
        int exp_reqs;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        inv_valid    = 1'b0;
        inv_addr     = '0;
        exp_mem_addr = '0;
        exp_mem_len  = '0;

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 50) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset release");
        end

        // init clear, the first busy cycle falls before the first sample
        busy_cycles = 0;
        @(negedge clk);
        while (stall && busy_cycles < TIMEOUT_CYCLES) begin
            assert (!mem_req) else report_mismatch("mem_req_o", 32'd0, 32'(mem_req));
            busy_cycles++;
            @(negedge clk);
        end
        if (stall) begin
            report_timeout("stall_o to fall after reset");
        end
        assert (busy_cycles == SET_NUM - 1)
            else report_mismatch("stall_o cycles", 32'(SET_NUM - 1), 32'(busy_cycles));

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            req_start = req_count;
            expect_mem_request(stim_table[i].addr);
            if (stim_table[i].inv) begin
                send_invalidate(stim_table[i].addr);
            end else begin
                run_fetches(stim_table[i].addr, 1, 1'b0);
            end
            exp_reqs = 32'(stim_table[i].reqs);
            assert (req_count - req_start == exp_reqs)
                else report_mismatch("mem_req_o count", 32'(exp_reqs),
                                     32'(req_count - req_start));
        end

        // back-to-back hits over the block loaded last
        req_start = req_count;
        expect_mem_request(32'h0000_5180);
        run_fetches(32'h0000_5180, BLOCK_WORDS, 1'b1);
        assert (req_count == req_start)
            else report_mismatch("mem_req_o count", 32'd0, 32'(req_count - req_start));

        err_count = err_count + req_errors;
        $display("responses=%0d mem_requests=%0d errors=%0d timeouts=%0d",
                 resp_count, req_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;
    end

endmodule
